//--- verif/dstr_input.txt
# W port sop eop valid_bytes data : ingress word in send order, valid_bytes 0 means 16
# E port data valid_bytes sop eop : expected egress beat, in order within each port
W 0 1 0 0 000102030405060708090a0b0c0d0e0f
W 1 1 1 12 202122232425262728292a2b2c2d2e2f
W 2 1 1 0 303132333435363738393a3b3c3d3e3f
W 0 0 1 7 101112131415161718191a1b1c1d1e1f
# burst of one-beat packets to port 3
W 3 1 1 4 606060600123456789abcdef01234567
W 3 1 1 1 616161610123456789abcdef01234567
W 3 1 1 2 626262620123456789abcdef01234567
W 3 1 1 3 636363630123456789abcdef01234567
W 3 1 1 4 646464640123456789abcdef01234567
W 3 1 1 1 656565650123456789abcdef01234567
W 3 1 1 2 666666660123456789abcdef01234567
W 3 1 1 3 676767670123456789abcdef01234567
W 2 1 0 0 707172737475767778797a7b7c7d7e7f
W 2 0 1 10 808182838485868788898a8b8c8d8e8f
E 0 00010203 4 1 0
E 0 04050607 4 0 0
E 0 08090a0b 4 0 0
E 0 0c0d0e0f 4 0 0
E 0 10111213 4 0 0
E 0 14151617 3 0 1
E 1 20212223 4 1 0
E 1 24252627 4 0 0
E 1 28292a2b 4 0 1
E 2 30313233 4 1 0
E 2 34353637 4 0 0
E 2 38393a3b 4 0 0
E 2 3c3d3e3f 4 0 1
E 2 70717273 4 1 0
E 2 74757677 4 0 0
E 2 78797a7b 4 0 0
E 2 7c7d7e7f 4 0 0
E 2 80818283 4 0 0
E 2 84858687 4 0 0
E 2 88898a8b 2 0 1
E 3 60606060 4 1 1
E 3 61616161 1 1 1
E 3 62626262 2 1 1
E 3 63636363 3 1 1
E 3 64646464 4 1 1
E 3 65656565 1 1 1
E 3 66666666 2 1 1
E 3 67676767 3 1 1

//--- all.f
source/dstr_cfg_pkg.sv
source/dstr_types_pkg.sv
source/event_queue.sv
source/packet_buffer.sv
source/port_reader.sv
source/dstr_top.sv
verif/tb_dstr.sv

//--- run.sh
#!/bin/sh
# builds tb_dstr with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module tb_dstr -f all.f || exit 1
./obj_dir/Vtb_dstr > sim.log 2>&1 || echo "simulator exited with an error status" >> sim.log
cat sim.log
grep -q "Checks failed" sim.log && echo "simulation failed" && exit 1
grep -q "simulator exited with an error status" sim.log && exit 1
echo "simulation passed" && exit 0

//--- verif/tb_dstr.sv
//##############################
// testbench for dstr_top.
// stimulus and expected beats come from verif/dstr_input.txt,
// so the run must start in the project root.
//##############################
`timescale 1ns/10ps

module tb_dstr;

	typedef struct packed {
		dstr_types_pkg::port_id_t port;
		logic sop;
		logic eop;
		dstr_types_pkg::word_vb_t vb;
		dstr_types_pkg::word_t data;
	} word_rec_t;

	typedef struct packed {
		dstr_types_pkg::beat_t data;
		dstr_types_pkg::beat_vb_t vb;
		logic sop;
		logic eop;
	} beat_rec_t;

	logic clk = 1'b0;
	logic rst_n;
	logic in_valid;
	dstr_types_pkg::word_t in_data;
	dstr_types_pkg::port_id_t in_port_id;
	logic in_sop;
	logic in_eop;
	dstr_types_pkg::word_vb_t in_valid_bytes;
	logic [dstr_cfg_pkg::num_ports-1:0] in_bp;
	logic [dstr_cfg_pkg::num_ports-1:0] port_bp = '0;
	logic [dstr_cfg_pkg::num_ports-1:0] out_valid;
	dstr_types_pkg::beat_t out_data [dstr_cfg_pkg::num_ports];
	logic [dstr_cfg_pkg::num_ports-1:0] out_sop;
	logic [dstr_cfg_pkg::num_ports-1:0] out_eop;
	dstr_types_pkg::beat_vb_t out_valid_bytes [dstr_cfg_pkg::num_ports];

	word_rec_t word_q [$];
	beat_rec_t exp_q [dstr_cfg_pkg::num_ports][$]; // expected beats, one queue per port.
	logic [31:0] lfsr_state = 32'hea171ce3;
	logic [dstr_cfg_pkg::num_ports-1:0] bp_seen = '0;
	int cycle_count = 0;
	int cycle_limit = 200;
	int mismatches = 0;
	int unexpected = 0;
	int other_errors = 0;
	int timeouts = 0;

	dstr_top u_dut (
		.clk             (clk),
		.rst_n           (rst_n),
		.in_valid        (in_valid),
		.in_data         (in_data),
		.in_port_id      (in_port_id),
		.in_sop          (in_sop),
		.in_eop          (in_eop),
		.in_valid_bytes  (in_valid_bytes),
		.in_bp           (in_bp),
		.port_bp         (port_bp),
		.out_valid       (out_valid),
		.out_data        (out_data),
		.out_sop         (out_sop),
		.out_eop         (out_eop),
		.out_valid_bytes (out_valid_bytes)
	);

	always #10 clk = ~clk;

	// Galois form of x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		logic [31:0] nxt;
		nxt = state >> 1;
		if (state[0])
			nxt = nxt ^ 32'h80200003;
		return nxt;
	endfunction

	function automatic int beats_left();
		int total;
		total = 0;
		for (int p = 0; p < dstr_cfg_pkg::num_ports; p++)
			total += exp_q[p].size();
		return total;
	endfunction

	task automatic load_file();
		int fd;
		int n;
		int port;
		int sop;
		int eop;
		int vb;
		byte kind;
		string line;
		logic [127:0] wdata;
		logic [31:0] bdata;
		word_rec_t w;
		beat_rec_t b;
		fd = $fopen("verif/dstr_input.txt", "r");
		if (fd == 0) begin
			other_errors++;
			$display("could not open verif/dstr_input.txt");
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.getc(0) == "W") begin
					n = $sscanf(line, "%c %d %d %d %d %h", kind, port, sop, eop, vb, wdata);
					w.port = dstr_types_pkg::port_id_t'(port);
					w.sop = sop[0];
					w.eop = eop[0];
					w.vb = dstr_types_pkg::word_vb_t'(vb);
					w.data = wdata;
					if (n == 6)
						word_q.push_back(w);
					else
						other_errors++;
				end else if (line.getc(0) == "E") begin
					n = $sscanf(line, "%c %d %h %d %d %d", kind, port, bdata, vb, sop, eop);
					b.data = bdata;
					b.vb = dstr_types_pkg::beat_vb_t'(vb);
					b.sop = sop[0];
					b.eop = eop[0];
					if (n == 6 && port >= 0 && port < dstr_cfg_pkg::num_ports)
						exp_q[port].push_back(b);
					else
						other_errors++;
				end
			end
			$fclose(fd);
			if (other_errors != 0)
				$display("input file has %0d malformed records", other_errors);
		end
	endtask

	// waits out in_bp of the target port, then presents the word.
	task automatic send_word(input word_rec_t w);
		@(posedge clk);
		while (in_bp[w.port]) begin
			in_valid <= 1'b0;
			@(posedge clk);
		end
		in_valid <= 1'b1;
		in_port_id <= w.port;
		in_sop <= w.sop;
		in_eop <= w.eop;
		in_valid_bytes <= w.vb;
		in_data <= w.data;
	endtask

	task automatic check_beat(input int p, input beat_rec_t want);
		assert (out_data[p] == want.data)
		else begin
			mismatches++;
			$display("[FAIL] %0t out_data[%0d] got %h expected %h",
				$time, p, out_data[p], want.data);
		end
		assert (out_valid_bytes[p] == want.vb)
		else begin
			mismatches++;
			$display("[FAIL] %0t out_valid_bytes[%0d] got %0d expected %0d",
				$time, p, out_valid_bytes[p], want.vb);
		end
		assert (out_sop[p] == want.sop)
		else begin
			mismatches++;
			$display("[FAIL] %0t out_sop[%0d] got %b expected %b", $time, p, out_sop[p], want.sop);
		end
		assert (out_eop[p] == want.eop)
		else begin
			mismatches++;
			$display("[FAIL] %0t out_eop[%0d] got %b expected %b", $time, p, out_eop[p], want.eop);
		end
	endtask

	task automatic finish_run();
		int missing;
		missing = 0;
		for (int p = 0; p < dstr_cfg_pkg::num_ports; p++) begin
			if (exp_q[p].size() != 0)
				$display("port %0d: %0d expected beats never arrived", p, exp_q[p].size());
			missing += exp_q[p].size();
		end
		$display("errors: %0d mismatched, %0d unexpected, %0d missing, %0d other, %0d timeout",
			mismatches, unexpected, missing, other_errors, timeouts);
		if (mismatches + unexpected + missing + other_errors + timeouts == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	endtask

	always @(posedge clk) begin
		if (!rst_n) begin
			port_bp <= '0;
		end else begin
			for (int p = 0; p < dstr_cfg_pkg::num_ports; p++) begin
				lfsr_state = lfsr_next(lfsr_state); // one step per bit.
				port_bp[p] <= lfsr_state[0];
			end
		end
	end

	// outputs are settled at the falling edge.
	always @(negedge clk) begin : monitor
		beat_rec_t want;
		if (rst_n) begin
			bp_seen = bp_seen | in_bp;
			for (int p = 0; p < dstr_cfg_pkg::num_ports; p++) begin
				if (out_valid[p]) begin
					if (exp_q[p].size() == 0) begin
						unexpected++;
						$display("%0t: port %0d sent beat %h with no beat expected",
							$time, p, out_data[p]);
					end else begin
						want = exp_q[p].pop_front();
						check_beat(p, want);
					end
				end
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= cycle_limit) begin
			timeouts++;
			$display("run stopped after %0d cycles with %0d beats still expected",
				cycle_count, beats_left());
			finish_run();
		end
	end

	initial begin
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_data = '0;
		in_port_id = '0;
		in_sop = 1'b0;
		in_eop = 1'b0;
		in_valid_bytes = '0;
		load_file();
		cycle_limit = word_q.size() * dstr_cfg_pkg::num_ports * 8 + 200;
		if (other_errors != 0) begin
			finish_run();
		end else begin
			repeat (3) @(posedge clk);
			rst_n <= 1'b1;
			@(negedge clk);
			assert (out_valid == '0)
			else begin
				other_errors++;
				$display("[FAIL] %0t out_valid got %b expected %b", $time, out_valid, 4'b0000);
			end
			assert (in_bp == '0)
			else begin
				other_errors++;
				$display("[FAIL] %0t in_bp got %b expected %b", $time, in_bp, 4'b0000);
			end
			foreach (word_q[i])
				send_word(word_q[i]);
			@(posedge clk);
			in_valid <= 1'b0;
			while (beats_left() != 0)
				@(posedge clk);
			repeat (8) @(negedge clk); // room for stray beats.
			assert (bp_seen != '0)
			else begin
				other_errors++;
				$display("in_bp never rose during the ingress burst");
			end
			assert (in_bp == '0)
			else begin
				other_errors++;
				$display("[FAIL] %0t in_bp got %b expected %b", $time, in_bp, 4'b0000);
			end
			finish_run();
		end
	end

endmodule

//--- source/dstr_top.sv
//##############################
// four-port packet distributor.
// no ingress ready; the source stops sending to a port
// while its in_bp bit is high.
//##############################
`timescale 1ns/10ps

module dstr_top (
	input  logic                     clk,
	input  logic                     rst_n,

	input  logic                     in_valid,
	input  dstr_types_pkg::word_t    in_data,
	input  dstr_types_pkg::port_id_t in_port_id,
	input  logic                     in_sop,
	input  logic                     in_eop,
	input  dstr_types_pkg::word_vb_t in_valid_bytes,
	output logic [dstr_cfg_pkg::num_ports-1:0] in_bp,

	input  logic [dstr_cfg_pkg::num_ports-1:0] port_bp,
	output logic [dstr_cfg_pkg::num_ports-1:0] out_valid,
	output dstr_types_pkg::beat_t    out_data [dstr_cfg_pkg::num_ports],
	output logic [dstr_cfg_pkg::num_ports-1:0] out_sop,
	output logic [dstr_cfg_pkg::num_ports-1:0] out_eop,
	output dstr_types_pkg::beat_vb_t out_valid_bytes [dstr_cfg_pkg::num_ports]
);

	dstr_types_pkg::queue_ptr_t wr_ptr [dstr_cfg_pkg::num_ports];
	dstr_types_pkg::queue_ptr_t rd_ptr [dstr_cfg_pkg::num_ports];
	dstr_types_pkg::desc_t head [dstr_cfg_pkg::num_ports];
	logic [dstr_cfg_pkg::num_ports-1:0] empty;
	logic [dstr_cfg_pkg::num_ports-1:0] pop;
	logic [dstr_cfg_pkg::num_ports-1:0] slot_grant;
	dstr_types_pkg::word_t rd_word;

	packet_buffer u_buffer (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_port_id (in_port_id),
		.in_data    (in_data),
		.wr_ptr     (wr_ptr),
		.rd_ptr     (rd_ptr),
		.slot_grant (slot_grant),
		.rd_word    (rd_word)
	);

	for (genvar p = 0; p < dstr_cfg_pkg::num_ports; p++) begin : g_port
		event_queue #(
			.port_index (p)
		) u_queue (
			.clk            (clk),
			.rst_n          (rst_n),
			.in_valid       (in_valid),
			.in_port_id     (in_port_id),
			.in_sop         (in_sop),
			.in_eop         (in_eop),
			.in_valid_bytes (in_valid_bytes),
			.pop            (pop[p]),
			.head           (head[p]),
			.empty          (empty[p]),
			.wr_ptr         (wr_ptr[p]),
			.rd_ptr         (rd_ptr[p]),
			.bp             (in_bp[p])
		);

		port_reader u_reader (
			.clk             (clk),
			.rst_n           (rst_n),
			.grant           (slot_grant[p]),
			.head            (head[p]),
			.empty           (empty[p]),
			.port_bp         (port_bp[p]),
			.rd_word         (rd_word), // shared, only the granted reader loads it.
			.pop             (pop[p]),
			.out_valid       (out_valid[p]),
			.out_data        (out_data[p]),
			.out_sop         (out_sop[p]),
			.out_eop         (out_eop[p]),
			.out_valid_bytes (out_valid_bytes[p])
		);
	end

endmodule

//--- source/port_reader.sv
//##############################
// one egress lane, slicing words into 32-bit beats.
// first beat is the most significant slice.
// port_bp only holds off the next word; a loaded word
// always runs to its last beat.
//##############################
`timescale 1ns/10ps

module port_reader (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     grant,
	input  dstr_types_pkg::desc_t    head,
	input  logic                     empty,
	input  logic                     port_bp,
	input  dstr_types_pkg::word_t    rd_word,
	output logic                     pop,
	output logic                     out_valid,
	output dstr_types_pkg::beat_t    out_data,
	output logic                     out_sop,
	output logic                     out_eop,
	output dstr_types_pkg::beat_vb_t out_valid_bytes
);

	logic load_q;
	dstr_types_pkg::desc_t desc_q; // descriptor of the word coming out of the buffer.
	dstr_types_pkg::word_t word_q;
	logic sop_q;
	logic eop_q;
	logic [$clog2(dstr_cfg_pkg::beats_per_word)-1:0] seq_q;
	logic [$clog2(dstr_cfg_pkg::word_bytes):0] rem_q;
	logic last;

	assign out_valid = (rem_q != '0);
	assign last = (rem_q <= dstr_cfg_pkg::beat_bytes);

	// at most one beat left after this one, so the new word follows seamlessly.
	assign pop = grant && !empty && !port_bp && (rem_q <= 2 * dstr_cfg_pkg::beat_bytes);

	assign out_data = word_q[(dstr_cfg_pkg::beats_per_word - 1 - seq_q) *
		$bits(dstr_types_pkg::beat_t) +: $bits(dstr_types_pkg::beat_t)];
	assign out_sop = out_valid && sop_q && (seq_q == '0);
	assign out_eop = out_valid && eop_q && last;
	assign out_valid_bytes = last ? dstr_types_pkg::beat_vb_t'(rem_q) :
		dstr_types_pkg::beat_vb_t'(dstr_cfg_pkg::beat_bytes);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			load_q <= 1'b0;
			rem_q <= '0;
			seq_q <= '0;
		end else begin
			load_q <= pop; // word shows on rd_word next cycle.
			if (load_q) begin
				rem_q <= desc_q.bytes;
				seq_q <= '0;
			end else if (out_valid) begin
				rem_q <= last ? '0 :
					rem_q - dstr_types_pkg::beat_vb_t'(dstr_cfg_pkg::beat_bytes);
				seq_q <= seq_q + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pop)
			desc_q <= head;
		if (load_q) begin
			word_q <= rd_word;
			sop_q <= desc_q.sop;
			eop_q <= desc_q.eop;
		end
	end

	// the pop condition must leave only the closing beat by load time.
	a_load_at_boundary: assert property (@(posedge clk) disable iff (!rst_n)
		load_q |-> rem_q <= dstr_cfg_pkg::beat_bytes)
		else $error("port_reader loaded with %0d bytes still pending", rem_q);

endmodule

//--- source/packet_buffer.sv
//##############################
// shared word storage, one slot region per port.
// reads follow a one-hot grant that visits each port
// once every num_ports cycles; read latency is 1.
//##############################
`timescale 1ns/10ps

module packet_buffer (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       in_valid,
	input  dstr_types_pkg::port_id_t   in_port_id,
	input  dstr_types_pkg::word_t      in_data,
	input  dstr_types_pkg::queue_ptr_t wr_ptr [dstr_cfg_pkg::num_ports],
	input  dstr_types_pkg::queue_ptr_t rd_ptr [dstr_cfg_pkg::num_ports],
	output logic [dstr_cfg_pkg::num_ports-1:0] slot_grant,
	output dstr_types_pkg::word_t      rd_word
);

	dstr_types_pkg::word_t mem [dstr_cfg_pkg::num_ports * 2**dstr_cfg_pkg::queue_depth_bits];
	dstr_types_pkg::port_id_t sel_id;

	// index of the granted port.
	always_comb begin
		sel_id = '0;
		for (int p = 0; p < dstr_cfg_pkg::num_ports; p++) begin
			if (slot_grant[p])
				sel_id = dstr_types_pkg::port_id_t'(p);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			slot_grant <= dstr_cfg_pkg::num_ports'(1); // port 0 first.
		else
			slot_grant <= {slot_grant[dstr_cfg_pkg::num_ports-2:0],
				slot_grant[dstr_cfg_pkg::num_ports-1]};
	end

	// write lands at the tail of the port's queue region.
	always_ff @(posedge clk) begin
		if (in_valid)
			mem[{in_port_id, wr_ptr[in_port_id]}] <= in_data;
	end

	// head word of the granted port, read every cycle.
	always_ff @(posedge clk) begin
		rd_word <= mem[{sel_id, rd_ptr[sel_id]}];
	end

	a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot(slot_grant))
		else $error("slot_grant not one-hot: %b", slot_grant);

endmodule

//--- source/event_queue.sv
//##############################
// per-port descriptor FIFO with XOFF/XON back-pressure.
// the source must obey bp; a write when full is an error.
//##############################
`timescale 1ns/10ps

module event_queue #(
	parameter int port_index = 0
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       in_valid,
	input  dstr_types_pkg::port_id_t   in_port_id,
	input  logic                       in_sop,
	input  logic                       in_eop,
	input  dstr_types_pkg::word_vb_t   in_valid_bytes,
	input  logic                       pop,
	output dstr_types_pkg::desc_t      head,
	output logic                       empty,
	output dstr_types_pkg::queue_ptr_t wr_ptr,
	output dstr_types_pkg::queue_ptr_t rd_ptr,
	output logic                       bp
);

	logic wr_en;
	logic full;
	logic [dstr_cfg_pkg::queue_depth_bits:0] count;
	logic [dstr_cfg_pkg::queue_depth_bits:0] count_nxt;
	dstr_types_pkg::desc_t wr_desc;
	dstr_types_pkg::desc_t mem [2**dstr_cfg_pkg::queue_depth_bits];

	assign wr_en = in_valid && (in_port_id == dstr_types_pkg::port_id_t'(port_index));
	assign full = count[dstr_cfg_pkg::queue_depth_bits]; // only set at exactly depth.
	assign empty = (count == '0);
	assign head = mem[rd_ptr];

	always_comb begin
		wr_desc.sop = in_sop;
		wr_desc.eop = in_eop;
		wr_desc.bytes = {in_valid_bytes == '0, in_valid_bytes}; // 0 becomes 16.
	end

	always_comb begin
		case ({wr_en, pop})
			2'b10: count_nxt = count + 1'b1;
			2'b01: count_nxt = count - 1'b1;
			default: count_nxt = count;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			bp <= 1'b0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count_nxt;
			if (count_nxt > dstr_cfg_pkg::xoff_level)
				bp <= 1'b1;
			else if (count_nxt < dstr_cfg_pkg::xon_level)
				bp <= 1'b0; // held in between.
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr] <= wr_desc;
	end

	a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n) !(wr_en && full))
		else $error("event_queue %0d written while full", port_index);

	a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) !(pop && empty))
		else $error("event_queue %0d popped while empty", port_index);

endmodule

//--- source/dstr_types_pkg.sv
//##############################
// data and descriptor types of the distributor.
// all widths follow dstr_cfg_pkg.
//##############################

package dstr_types_pkg;

	typedef logic [dstr_cfg_pkg::word_bytes*8-1:0] word_t;
	typedef logic [dstr_cfg_pkg::beat_bytes*8-1:0] beat_t;

	typedef logic [$clog2(dstr_cfg_pkg::num_ports)-1:0] port_id_t;
	typedef logic [dstr_cfg_pkg::queue_depth_bits-1:0] queue_ptr_t;

	// ingress valid bytes, 0 stands for a full word.
	typedef logic [$clog2(dstr_cfg_pkg::word_bytes)-1:0] word_vb_t;

	// egress valid bytes, 1 to beat_bytes.
	typedef logic [$clog2(dstr_cfg_pkg::beat_bytes):0] beat_vb_t;

	// one stored word descriptor; bytes runs 1 to word_bytes.
	typedef struct packed {
		logic sop;
		logic eop;
		logic [$clog2(dstr_cfg_pkg::word_bytes):0] bytes;
	} desc_t;

endpackage

//--- source/dstr_cfg_pkg.sv
//##############################
// distributor sizing constants.
// xoff_level + 3 must not exceed the queue depth, because
// the source reacts one cycle after in_bp rises.
//##############################

package dstr_cfg_pkg;

	localparam int num_ports = 4;

	// ingress word and egress beat sizes in bytes.
	localparam int word_bytes = 16;
	localparam int beat_bytes = 4;
	localparam int beats_per_word = word_bytes / beat_bytes;

	// per-port event queue of 8 entries.
	localparam int queue_depth_bits = 3;

	// hysteresis on queue occupancy.
	localparam int xoff_level = 5; // bp rises above this.
	localparam int xon_level = 3;  // bp falls below this.

endpackage
